// File: all.f
histPkg.sv
histRam.sv
histBankMux.sv
histAccumulator.sv
peakScanner.sv
histTop.sv
histTop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simBin=histTop_sim

verilator --binary --timing -f all.f --top-module histTop_tb --Mdir obj_dir -o "$simBin"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TEST FAILED" "$logFile"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

echo "simulation passed"
exit 0

// File: histTop_tb.sv
`timescale 1ns/1ns
`default_nettype none

module histTop_tb;

    localparam int rowNum = 12;
    localparam int resetCycles = 5;
    localparam int partialSamples = 10;
    // quiet cycles after the last result to catch a stray pulse
    localparam int tailCycles = 30;
    // gapped pixel plus scan latency per row, then two reset and clear passes
    localparam int watchCycles = rowNum * (histPkg::samplesPerPixel * 4 + 40)
        + 2 * (resetCycles + histPkg::binNum + 40) + tailCycles;
    localparam logic [15:0] lfsrSeed = 16'd40392;

    logic clk;
    logic reset;
    logic wrEn;
    histPkg::sampleT data;
    logic ready;
    logic peakValid;
    histPkg::pixelT peakPixel;
    histPkg::binT peakBin;
    histPkg::countT peakCount;

    // stimulus table, one named pixel case per row
    string caseName [rowNum];
    logic isRandom [rowNum];
    logic useGap [rowNum];
    logic midReset [rowNum];
    int tableBin [rowNum];
    int tableCount [rowNum];
    histPkg::sampleT stim [rowNum][histPkg::samplesPerPixel];

    // samples of the pixel being sent
    histPkg::sampleT pixelSamples [histPkg::samplesPerPixel];
    logic [15:0] lfsr;
    int pixelIdx;
    int expBinVal;
    int expCountVal;

    // results still owed by the DUT, oldest first
    string expName [$];
    int expPixel [$];
    int expBin [$];
    int expCount [$];

    histTop DUT (
        .clk(clk), .reset(reset), .wrEn(wrEn), .data(data),
        .ready(ready), .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(string testName, string field, logic [31:0] expected,
                              logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected %0d actual %0d", testName, field, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", testName);
        end
    endtask

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int randomBits(int width);
        int value;
        value = 0;
        for (int i = 0; i < width; i++) begin
            value = (value << 1) | int'(nextBit());
        end
        return value;
    endfunction

    // reference histogram, highest count wins and the lowest bin breaks ties
    task automatic modelPeak(output int bin, output int count);
        int hist [histPkg::binNum];
        histPkg::binT sampleBin;
        for (int b = 0; b < histPkg::binNum; b++) begin
            hist[b] = 0;
        end
        for (int i = 0; i < histPkg::samplesPerPixel; i++) begin
            sampleBin = histPkg::binT'(pixelSamples[i]
                >> (histPkg::sampleWidth - histPkg::binBits));
            hist[sampleBin]++;
        end
        bin = 0;
        count = hist[0];
        for (int b = 1; b < histPkg::binNum; b++) begin
            if (hist[b] > count) begin
                bin = b;
                count = hist[b];
            end
        end
    endtask

    task automatic setRow(int row, string name, logic rnd, logic gap, logic rst,
                          int bin, int count);
        caseName[row] = name;
        isRandom[row] = rnd;
        useGap[row] = gap;
        midReset[row] = rst;
        tableBin[row] = bin;
        tableCount[row] = count;
    endtask

    task automatic fillTable();
        setRow(0, "sameBin", 1'b0, 1'b0, 1'b0, 5, 20);
        setRow(1, "tieLow", 1'b0, 1'b0, 1'b0, 3, 8);
        setRow(2, "tieGap", 1'b0, 1'b1, 1'b0, 2, 10);
        setRow(3, "randomA", 1'b1, 1'b0, 1'b0, 0, 0);
        // pixel index wraps here
        setRow(4, "randomB", 1'b1, 1'b0, 1'b0, 0, 0);
        setRow(5, "randomGapA", 1'b1, 1'b1, 1'b0, 0, 0);
        setRow(6, "randomGapB", 1'b1, 1'b1, 1'b0, 0, 0);
        setRow(7, "randomC", 1'b1, 1'b0, 1'b0, 0, 0);
        // tieLow again after an aborted pixel, a leak into bin 15 would win
        setRow(8, "resetMid", 1'b0, 1'b0, 1'b1, 3, 8);
        setRow(9, "randomGapC", 1'b1, 1'b1, 1'b0, 0, 0);
        setRow(10, "randomD", 1'b1, 1'b0, 1'b0, 0, 0);
        setRow(11, "randomE", 1'b1, 1'b0, 1'b0, 0, 0);
        // every sample in bin 5, back to back
        for (int i = 0; i < histPkg::samplesPerPixel; i++) begin
            stim[0][i] = {4'd5, 6'(i * 3)};
        end
        // bins 9 and 3 eight times each, bin 9 arrives first
        stim[1] = '{10'h241, 10'h0c2, 10'h25f, 10'h0d0, 10'h27f, 10'h0ff, 10'h240,
                    10'h0c0, 10'h301, 10'h03f, 10'h262, 10'h0e1, 10'h24a, 10'h0c9,
                    10'h270, 10'h0f7, 10'h255, 10'h0d5, 10'h3c4, 10'h077};
        // bins 14 and 2 ten times each
        stim[2] = '{10'h380, 10'h3bf, 10'h081, 10'h0be, 10'h391, 10'h3a2, 10'h090,
                    10'h0a5, 10'h385, 10'h3b0, 10'h0b3, 10'h08c, 10'h39d, 10'h3aa,
                    10'h09e, 10'h0b9, 10'h38f, 10'h3b7, 10'h0a0, 10'h082};
        for (int i = 0; i < histPkg::samplesPerPixel; i++) begin
            stim[8][i] = stim[1][i];
        end
    endtask

    // inputs change 1 ns after the rising edge
    task nextCycle();
        @(posedge clk);
        #1;
    endtask

    task sendSample(histPkg::sampleT value, logic gapOn);
        if (gapOn) begin
            repeat (randomBits(2)) nextCycle();
        end
        wrEn = 1'b1;
        data = value;
        nextCycle();
        wrEn = 1'b0;
    endtask

    task applyReset();
        reset = 1'b1;
        repeat (resetCycles) nextCycle();
        reset = 1'b0;
    endtask

    // bank clear takes binNum cycles and must finish within 16+2
    task waitReady();
        int waited;
        waited = 0;
        checkValue("resetReady", "ready", 0, 32'(ready));
        while (ready !== 1'b1 && waited < histPkg::binNum + 2) begin
            nextCycle();
            waited++;
        end
        if (ready !== 1'b1) begin
            $display("ready did not rise within %0d cycles of reset", histPkg::binNum + 2);
            $display("TEST FAILED");
            $fatal(1, "bank clear too slow");
        end
        if (waited < histPkg::binNum) begin
            $display("ready rose after %0d cycles, before the bank clear was over", waited);
            $display("TEST FAILED");
            $fatal(1, "bank clear too short");
        end
    endtask

    task drainResults();
        while (expName.size() != 0) begin
            nextCycle();
        end
    endtask

    // outputs are read at the falling edge, away from the drive point
    always @(negedge clk) begin
        if (peakValid === 1'b1) begin
            if (expName.size() == 0) begin
                $display("peakValid arrived with no pixel pending");
                $display("TEST FAILED");
                $fatal(1, "spurious result");
            end else begin
                checkValue(expName[0], "peakPixel", expPixel[0], 32'(peakPixel));
                checkValue(expName[0], "peakBin", expBin[0], 32'(peakBin));
                checkValue(expName[0], "peakCount", expCount[0], 32'(peakCount));
                void'(expName.pop_front());
                void'(expPixel.pop_front());
                void'(expBin.pop_front());
                void'(expCount.pop_front());
            end
        end
    end

    initial begin
        repeat (watchCycles) @(posedge clk);
        $display("Timeout: results did not arrive after %0d cycles", watchCycles);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        wrEn = 1'b0;
        data = '0;
        lfsr = lfsrSeed;
        pixelIdx = 0;
        fillTable();
        applyReset();
        waitReady();

        for (int r = 0; r < rowNum; r++) begin
            if (midReset[r]) begin
                drainResults();
                // half a pixel in bin 15, then lost to the reset
                for (int i = 0; i < partialSamples; i++) begin
                    sendSample(histPkg::sampleT'(10'h3c0 + i), 1'b0);
                end
                applyReset();
                waitReady();
                pixelIdx = 0;
            end
            for (int i = 0; i < histPkg::samplesPerPixel; i++) begin
                if (isRandom[r]) begin
                    pixelSamples[i] = histPkg::sampleT'(randomBits(histPkg::sampleWidth));
                end else begin
                    pixelSamples[i] = stim[r][i];
                end
            end
            if (isRandom[r]) begin
                modelPeak(expBinVal, expCountVal);
            end else begin
                expBinVal = tableBin[r];
                expCountVal = tableCount[r];
            end
            expName.push_back(caseName[r]);
            expPixel.push_back(pixelIdx % histPkg::pixelNum);
            expBin.push_back(expBinVal);
            expCount.push_back(expCountVal);
            for (int i = 0; i < histPkg::samplesPerPixel; i++) begin
                sendSample(pixelSamples[i], useGap[r]);
            end
            pixelIdx++;
        end

        drainResults();
        repeat (tailCycles) nextCycle();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: histTop.sv
`timescale 1ns/1ns
`default_nettype none

module histTop (
    input wire clk,
    input wire logic reset,
    input wire logic wrEn,
    input wire histPkg::sampleT data,
    output logic ready,
    output logic peakValid,
    output histPkg::pixelT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount
);

    // accumulator ports
    histPkg::binT accRdAddr;
    histPkg::countT accRdCount;
    logic accWrEn;
    histPkg::binT accWrAddr;
    histPkg::countT accWrCount;
    logic activeBank;

    // pixel handoff
    logic pixelDone;
    histPkg::pixelT donePixel;

    // scanner ports
    histPkg::binT scanRdAddr;
    histPkg::countT scanRdCount;
    logic scanWrEn;
    histPkg::binT scanWrAddr;
    logic clearBoth;

    // bank ports
    histPkg::binT rdAddr0;
    histPkg::countT rdCount0;
    logic wrEn0;
    histPkg::binT wrAddr0;
    histPkg::countT wrCount0;
    histPkg::binT rdAddr1;
    histPkg::countT rdCount1;
    logic wrEn1;
    histPkg::binT wrAddr1;
    histPkg::countT wrCount1;

    histAccumulator accumulator (
        .clk(clk), .reset(reset), .ready(ready),
        .wrEn(wrEn), .data(data),
        .accRdAddr(accRdAddr), .accRdCount(accRdCount),
        .accWrEn(accWrEn), .accWrAddr(accWrAddr), .accWrCount(accWrCount),
        .activeBank(activeBank),
        .pixelDone(pixelDone), .donePixel(donePixel)
    );

    peakScanner scanner (
        .clk(clk), .reset(reset),
        .pixelDone(pixelDone), .donePixel(donePixel),
        .scanRdAddr(scanRdAddr), .scanRdCount(scanRdCount),
        .scanWrEn(scanWrEn), .scanWrAddr(scanWrAddr),
        .clearBoth(clearBoth), .ready(ready),
        .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    // ping-pong steering between the two banks
    histBankMux bankMux (
        .clk(clk), .activeBank(activeBank), .clearBoth(clearBoth),
        .accRdAddr(accRdAddr), .accRdCount(accRdCount),
        .accWrEn(accWrEn), .accWrAddr(accWrAddr), .accWrCount(accWrCount),
        .scanRdAddr(scanRdAddr), .scanRdCount(scanRdCount),
        .scanWrEn(scanWrEn), .scanWrAddr(scanWrAddr),
        .rdAddr0(rdAddr0), .rdCount0(rdCount0),
        .wrEn0(wrEn0), .wrAddr0(wrAddr0), .wrCount0(wrCount0),
        .rdAddr1(rdAddr1), .rdCount1(rdCount1),
        .wrEn1(wrEn1), .wrAddr1(wrAddr1), .wrCount1(wrCount1)
    );

    histRam bank0 (
        .clk(clk), .rdAddr(rdAddr0), .rdCount(rdCount0),
        .wrEn(wrEn0), .wrAddr(wrAddr0), .wrCount(wrCount0)
    );

    histRam bank1 (
        .clk(clk), .rdAddr(rdAddr1), .rdCount(rdCount1),
        .wrEn(wrEn1), .wrAddr(wrAddr1), .wrCount(wrCount1)
    );

endmodule

`default_nettype wire

// File: peakScanner.sv
`timescale 1ns/1ns
`default_nettype none

module peakScanner (
    input wire clk,
    input wire logic reset,
    input wire logic pixelDone,
    input wire histPkg::pixelT donePixel,
    output histPkg::binT scanRdAddr,
    input wire histPkg::countT scanRdCount,
    output logic scanWrEn,
    output histPkg::binT scanWrAddr,
    output logic clearBoth,
    output logic ready,
    output logic peakValid,
    output histPkg::pixelT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount
);

    typedef enum logic [1:0] {
        clearAll,
        idle,
        scan,
        report
    } stateT;

    stateT state;

    // read address, doubles as clear counter after reset
    histPkg::binT rdAddr;
    logic issuing;
    // one cycle behind the read, data valid and clear write
    logic cmpValid;
    histPkg::binT cmpAddr;

    histPkg::binT bestBin;
    histPkg::countT bestCount;
    histPkg::pixelT scanPixel;
    logic startScan;

    // a new pixel may show up right in the report cycle
    assign startScan = pixelDone && ((state == idle) || (state == report));

    assign scanRdAddr = rdAddr;
    // zero written right behind the read
    assign scanWrEn = cmpValid;
    assign scanWrAddr = cmpAddr;

    // open once the last clear write is done
    assign ready = (state != clearAll) && !clearBoth;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= clearAll;
            rdAddr <= '0;
            issuing <= 1'b0;
            cmpValid <= 1'b0;
            clearBoth <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= 1'b0;
            cmpValid <= (state == clearAll) || issuing;
            clearBoth <= (state == clearAll);

            case (state)
                clearAll: begin
                    rdAddr <= rdAddr + histPkg::binT'(1);
                    if (rdAddr == histPkg::binT'(histPkg::binNum - 1)) begin
                        state <= idle;
                    end
                end
                idle: begin
                    if (startScan) begin
                        state <= scan;
                        rdAddr <= '0;
                        issuing <= 1'b1;
                    end
                end
                scan: begin
                    if (issuing) begin
                        rdAddr <= rdAddr + histPkg::binT'(1);
                        if (rdAddr == histPkg::binT'(histPkg::binNum - 1)) begin
                            issuing <= 1'b0;
                        end
                    end else begin
                        // last count compared this cycle
                        state <= report;
                    end
                end
                report: begin
                    peakValid <= 1'b1;
                    if (startScan) begin
                        state <= scan;
                        rdAddr <= '0;
                        issuing <= 1'b1;
                    end else begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= clearAll;
                end
            endcase
        end
    end

    // running maximum and result registers
    always_ff @(posedge clk) begin
        cmpAddr <= rdAddr;
        if (startScan) begin
            scanPixel <= donePixel;
        end
        // bin 0 restarts the max, strict compare keeps the lowest bin on ties
        if (cmpValid && !clearBoth) begin
            if ((cmpAddr == '0) || (scanRdCount > bestCount)) begin
                bestCount <= scanRdCount;
                bestBin <= cmpAddr;
            end
        end
        if (state == report) begin
            peakPixel <= scanPixel;
            peakBin <= bestBin;
            peakCount <= bestCount;
        end
    end

endmodule

`default_nettype wire

// File: histAccumulator.sv
`timescale 1ns/1ns
`default_nettype none

module histAccumulator (
    input wire clk,
    input wire logic reset,
    input wire logic ready,
    input wire logic wrEn,
    input wire histPkg::sampleT data,
    // bank read port, one cycle latency
    output histPkg::binT accRdAddr,
    input wire histPkg::countT accRdCount,
    // bank write port
    output logic accWrEn,
    output histPkg::binT accWrAddr,
    output histPkg::countT accWrCount,
    output logic activeBank,
    // handoff to the scanner
    output logic pixelDone,
    output histPkg::pixelT donePixel
);

    // pixelStart means the next sample opens a pixel
    typedef enum logic {
        pixelStart,
        pixelMid
    } stateT;

    typedef logic [$clog2(histPkg::dataNum)-1:0] dataCntT;
    typedef logic [$clog2(histPkg::acqNum)-1:0] acqCntT;

    stateT state;
    dataCntT dataCnt;
    acqCntT acqCnt;
    histPkg::pixelT pixelCnt;

    histPkg::binT sampleBin;
    logic accept;
    logic lastData;
    logic lastAcq;
    logic lastSample;

    // write stage flags
    logic wrFirst;
    logic wrLast;
    logic fwdHit;
    histPkg::countT fwdCount;
    histPkg::countT baseCount;

    // bin from the sample msbs
    assign sampleBin = data[histPkg::sampleWidth-1 -: histPkg::binBits];

    // read issued in the strobe cycle
    assign accRdAddr = sampleBin;

    // nothing gets in while the bank clear runs
    assign accept = wrEn && ready;

    assign lastData = (dataCnt == dataCntT'(histPkg::dataNum - 1));
    assign lastAcq = (acqCnt == acqCntT'(histPkg::acqNum - 1));
    assign lastSample = lastData && lastAcq;

    // count source for the write
    // first sample of a pixel lands in a freshly cleared bank
    // the read for it may still hit the old bank around a swap
    always_comb begin
        if (wrFirst) begin
            baseCount = '0;
        end else if (fwdHit) begin
            baseCount = fwdCount;
        end else begin
            baseCount = accRdCount;
        end
    end

    assign accWrCount = baseCount + histPkg::countT'(1);

    // sample, acquisition and pixel counting
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pixelStart;
            dataCnt <= '0;
            acqCnt <= '0;
        end else begin
            case (state)
                pixelStart: begin
                    if (accept) begin
                        state <= pixelMid;
                    end
                end
                pixelMid: begin
                    if (accept && lastSample) begin
                        state <= pixelStart;
                    end
                end
                default: begin
                    state <= pixelStart;
                end
            endcase

            if (accept) begin
                if (lastData) begin
                    dataCnt <= '0;
                    acqCnt <= lastAcq ? '0 : acqCnt + acqCntT'(1);
                end else begin
                    dataCnt <= dataCnt + dataCntT'(1);
                end
            end
        end
    end

    // write stage and bank swap
    always_ff @(posedge clk) begin
        if (reset) begin
            accWrEn <= 1'b0;
            wrFirst <= 1'b0;
            wrLast <= 1'b0;
            fwdHit <= 1'b0;
            pixelDone <= 1'b0;
            activeBank <= 1'b0;
            pixelCnt <= '0;
        end else begin
            accWrEn <= accept;
            wrFirst <= accept && (state == pixelStart);
            wrLast <= accept && lastSample;
            // this read misses the write going on right now
            fwdHit <= accept && accWrEn && (sampleBin == accWrAddr);

            // one cycle after the last write of the pixel
            pixelDone <= wrLast;
            if (wrLast) begin
                activeBank <= !activeBank;
                if (pixelCnt == histPkg::pixelT'(histPkg::pixelNum - 1)) begin
                    pixelCnt <= '0;
                end else begin
                    pixelCnt <= pixelCnt + histPkg::pixelT'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        accWrAddr <= sampleBin;
        fwdCount <= accWrCount;
        if (wrLast) begin
            donePixel <= pixelCnt;
        end
    end

endmodule

`default_nettype wire

// File: histBankMux.sv
`timescale 1ns/1ns
`default_nettype none

module histBankMux (
    input wire clk,
    input wire logic activeBank,
    input wire logic clearBoth,
    // accumulator side
    input wire histPkg::binT accRdAddr,
    output histPkg::countT accRdCount,
    input wire logic accWrEn,
    input wire histPkg::binT accWrAddr,
    input wire histPkg::countT accWrCount,
    // scanner side
    input wire histPkg::binT scanRdAddr,
    output histPkg::countT scanRdCount,
    input wire logic scanWrEn,
    input wire histPkg::binT scanWrAddr,
    // bank 0
    output histPkg::binT rdAddr0,
    input wire histPkg::countT rdCount0,
    output logic wrEn0,
    output histPkg::binT wrAddr0,
    output histPkg::countT wrCount0,
    // bank 1
    output histPkg::binT rdAddr1,
    input wire histPkg::countT rdCount1,
    output logic wrEn1,
    output histPkg::binT wrAddr1,
    output histPkg::countT wrCount1
);

    // bank select as it was when the returning read was issued
    logic activeBankD;
    // scanner owns the write port of this bank
    logic scanWr0;
    logic scanWr1;

    always_ff @(posedge clk) begin
        activeBankD <= activeBank;
    end

    // reads follow the current owner
    assign rdAddr0 = activeBank ? scanRdAddr : accRdAddr;
    assign rdAddr1 = activeBank ? accRdAddr : scanRdAddr;

    // read data comes back from the bank addressed one cycle ago
    assign accRdCount = activeBankD ? rdCount1 : rdCount0;
    assign scanRdCount = activeBankD ? rdCount0 : rdCount1;

    // clear pass after reset hits both banks
    assign scanWr0 = clearBoth || activeBank;
    assign scanWr1 = clearBoth || !activeBank;

    assign wrEn0 = scanWr0 ? scanWrEn : accWrEn;
    assign wrAddr0 = scanWr0 ? scanWrAddr : accWrAddr;
    // scanner only ever writes zero
    assign wrCount0 = scanWr0 ? '0 : accWrCount;

    assign wrEn1 = scanWr1 ? scanWrEn : accWrEn;
    assign wrAddr1 = scanWr1 ? scanWrAddr : accWrAddr;
    assign wrCount1 = scanWr1 ? '0 : accWrCount;

endmodule

`default_nettype wire

// File: histRam.sv
`timescale 1ns/1ns
`default_nettype none

module histRam (
    input wire clk,
    input wire histPkg::binT rdAddr,
    output histPkg::countT rdCount,
    input wire logic wrEn,
    input wire histPkg::binT wrAddr,
    input wire histPkg::countT wrCount
);

    // one count per bin
    histPkg::countT mem [histPkg::binNum];

    // power-up contents, the scanner clears again after reset
    initial begin
        for (int i = 0; i < histPkg::binNum; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrCount;
        end
        // registered read, old data on a same-address write
        rdCount <= mem[rdAddr];
    end

endmodule

`default_nettype wire

// File: histPkg.sv
`default_nettype none

package histPkg;

    // raw time-of-flight sample
    localparam int sampleWidth = 10;

    // bin is the top bits of a sample
    localparam int binBits = 4;
    localparam int binNum = 1 << binBits;

    // per-bin counter
    localparam int countWidth = 8;

    // acquisitions per pixel, samples per acquisition
    localparam int acqNum = 5;
    localparam int dataNum = 4;
    localparam int samplesPerPixel = acqNum * dataNum;

    // pixels per frame
    localparam int pixelNum = 4;
    localparam int pixelBits = 2;

    typedef logic [sampleWidth-1:0] sampleT;
    typedef logic [binBits-1:0] binT;

    // 20 hits max per pixel, so no saturation needed
    typedef logic [countWidth-1:0] countT;

    typedef logic [pixelBits-1:0] pixelT;

endpackage

`default_nettype wire
